//--- sim.f
src/pcie_tlp_pkg.sv
src/core_cfg_pkg.sv
src/cq_req_decode.sv
src/bar_reg_file.sv
src/cc_cpl_gen.sv
src/example_core_pcie.sv
src/fpga_core.sv
test/clk_gen.sv
test/fpga_core_chk.sv
test/tb_fpga_core.sv

//--- src/bar_reg_file.sv
/* BAR0 register memory */

`timescale 1ns/10ps

module bar_reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_cfg_pkg::mem_req_t mem_req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output core_cfg_pkg::mem_rsp_t mem_rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready
);
    import pcie_tlp_pkg::*;
    import core_cfg_pkg::*;

    logic [31:0] regs [REG_DEPTH];
    logic        req_fire;
    logic        wr_commit;

    assign req_ready = !(rsp_valid && !rsp_ready);  // Stall behind a held response.
    assign req_fire  = req_valid && req_ready;
    assign wr_commit = req_fire && mem_req.is_write && !mem_req.is_unsup;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_commit) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.be[b]) begin
                    regs[mem_req.addr][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Reads and rejected requests both answer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire && !wr_commit) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !wr_commit) begin
            mem_rsp.rdata        <= mem_req.is_unsup ? 32'd0 : regs[mem_req.addr];
            mem_rsp.status       <= mem_req.is_unsup ? UR : SC;
            mem_rsp.tag          <= mem_req.tag;
            mem_rsp.requester_id <= mem_req.requester_id;
            mem_rsp.lower_addr   <= mem_req.lower_addr;
        end
    end

endmodule

//--- src/cc_cpl_gen.sv
/* CC completion generator */

`timescale 1ns/10ps

module cc_cpl_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_cfg_pkg::mem_rsp_t mem_rsp,
    input  logic                   rsp_valid,
    output logic                   rsp_ready,
    output pcie_tlp_pkg::cc_cpl_t  cc_cpl,
    output logic                   cc_valid,
    input  logic                   cc_ready
);
    import pcie_tlp_pkg::*;

    cc_cpl_t cpl_d;
    logic    rsp_fire;

    // Take a new response as the current beat leaves.
    assign rsp_ready = !cc_valid || cc_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;

    always_comb begin
        cpl_d.tag          = mem_rsp.tag;
        cpl_d.requester_id = mem_rsp.requester_id;
        cpl_d.status       = mem_rsp.status;
        cpl_d.lower_addr   = mem_rsp.lower_addr;
        cpl_d.data         = mem_rsp.rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc_valid <= 1'b0;
        end else if (rsp_fire) begin
            cc_valid <= 1'b1;
        end else if (cc_ready) begin
            cc_valid <= 1'b0;  // Beat taken, nothing behind it.
        end
    end

    // Held unchanged while the host stalls.
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            cc_cpl <= cpl_d;
        end
    end

endmodule

//--- src/core_cfg_pkg.sv
/* Core configuration and memory bus */

package core_cfg_pkg;

    localparam int BAR0_APERTURE = 10;                // 1 KiB.
    localparam int REG_ADDR_W    = BAR0_APERTURE - 2;
    localparam int REG_DEPTH     = 2 ** REG_ADDR_W;

    // Request from the decoder to the register file.
    typedef struct packed {
        logic                  is_write;
        logic                  is_unsup;
        logic [REG_ADDR_W-1:0] addr;
        logic [3:0]            be;
        logic [31:0]           wdata;
        logic [7:0]            tag;
        logic [15:0]           requester_id;
        logic [6:0]            lower_addr;
    } mem_req_t;

    typedef struct packed {
        logic [31:0]               rdata;
        pcie_tlp_pkg::cpl_status_e status;
        logic [7:0]                tag;
        logic [15:0]               requester_id;
        logic [6:0]                lower_addr;
    } mem_rsp_t;

endpackage

//--- src/cq_req_decode.sv
/* CQ request decoder */

`timescale 1ns/10ps

module cq_req_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pcie_tlp_pkg::cq_beat_t cq_beat,
    input  logic                   cq_valid,
    output logic                   cq_ready,
    output core_cfg_pkg::mem_req_t mem_req,
    output logic                   req_valid,
    input  logic                   req_ready,
    output logic                   unsup_pulse,
    output logic                   malformed
);
    import pcie_tlp_pkg::*;
    import core_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WR_DATA,
        HOLD
    } state_e;

    state_e  state;
    cq_hdr_t hdr;
    logic    hdr_unsup;
    logic    beat_fire;

    // Byte address of the first enabled byte, low 7 bits.
    function automatic logic [6:0] calc_lower_addr(input logic [15:0] dw_addr,
                                                   input logic [3:0]  be);
        logic [17:0] byte_addr;
        logic [1:0]  idx;
        idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (be[i]) begin
                idx = 2'(i);
            end
        end
        byte_addr = {dw_addr, 2'b00} + {16'd0, idx};
        return byte_addr[6:0];
    endfunction

    assign hdr       = cq_hdr_t'(cq_beat.data);
    assign cq_ready  = (state != HOLD);  // One request buffered.
    assign req_valid = (state == HOLD);
    assign beat_fire = cq_valid && cq_ready;
    assign hdr_unsup = (hdr.bar_id != 3'd0) || !(hdr.req_type inside {MEM_RD, MEM_WR});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            unsup_pulse <= 1'b0;
            malformed   <= 1'b0;
        end else begin
            unsup_pulse <= 1'b0;
            malformed   <= 1'b0;
            case (state)
                IDLE: begin
                    if (beat_fire) begin
                        if (cq_beat.last) begin
                            state       <= HOLD;
                            unsup_pulse <= hdr_unsup;
                        end else begin
                            state <= WR_DATA;  // Payload follows.
                        end
                    end
                end
                WR_DATA: begin
                    if (beat_fire) begin
                        if (cq_beat.last) begin
                            state       <= HOLD;
                            unsup_pulse <= mem_req.is_unsup;
                        end else begin
                            malformed <= 1'b1;  // Extra beat, keep absorbing.
                        end
                    end
                end
                HOLD: begin
                    if (req_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire) begin
            if (state == IDLE) begin
                mem_req.is_write     <= (hdr.req_type == MEM_WR);
                mem_req.is_unsup     <= hdr_unsup;
                mem_req.addr         <= hdr.dword_addr[REG_ADDR_W-1:0];
                mem_req.be           <= hdr.first_be;
                mem_req.wdata        <= '0;
                mem_req.tag          <= hdr.tag;
                mem_req.requester_id <= hdr.requester_id;
                mem_req.lower_addr   <= calc_lower_addr(hdr.dword_addr, hdr.first_be);
            end else begin
                mem_req.wdata <= cq_beat.data[31:0];  // Write data in low dword.
            end
        end
    end

endmodule

//--- src/example_core_pcie.sv
/* Example PCIe target core */

`timescale 1ns/10ps

module example_core_pcie (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pcie_tlp_pkg::cq_beat_t cq_beat,
    input  logic                   cq_valid,
    output logic                   cq_ready,
    output pcie_tlp_pkg::cc_cpl_t  cc_cpl,
    output logic                   cc_valid,
    input  logic                   cc_ready,
    output logic                   status_error_cor,
    output logic                   status_error_uncor
);
    import core_cfg_pkg::*;

    mem_req_t mem_req;
    logic     req_valid;
    logic     req_ready;
    mem_rsp_t mem_rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    logic     unsup_pulse;
    logic     malformed;

    cq_req_decode cq_req_decode_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cq_beat(cq_beat),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),
        .mem_req(mem_req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .unsup_pulse(unsup_pulse),
        .malformed(malformed)
    );

    bar_reg_file bar_reg_file_inst (
        .clk(clk),
        .rst_n(rst_n),
        .mem_req(mem_req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .mem_rsp(mem_rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready)
    );

    cc_cpl_gen cc_cpl_gen_inst (
        .clk(clk),
        .rst_n(rst_n),
        .mem_rsp(mem_rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_error_cor   <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            status_error_cor <= unsup_pulse;  // One cycle per UR request.
            if (malformed) begin
                status_error_uncor <= 1'b1;  // Sticky until reset.
            end
        end
    end

endmodule

//--- src/fpga_core.sv
/* FPGA core top */

`timescale 1ns/10ps

module fpga_core (
    // Clock and async reset.
    input  logic                   clk,
    input  logic                   rst_n,

    // Completer request.
    input  pcie_tlp_pkg::cq_beat_t cq_beat,
    input  logic                   cq_valid,
    output logic                   cq_ready,

    // Completer completion.
    output pcie_tlp_pkg::cc_cpl_t  cc_cpl,
    output logic                   cc_valid,
    input  logic                   cc_ready,

    output logic                   status_error_cor,
    output logic                   status_error_uncor
);

    example_core_pcie example_core_pcie_inst (
        .clk(clk),
        .rst_n(rst_n),

        .cq_beat(cq_beat),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),

        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready),

        .status_error_cor(status_error_cor),
        .status_error_uncor(status_error_uncor)
    );

endmodule

//--- src/pcie_tlp_pkg.sv
/* PCIe completer stream formats */

package pcie_tlp_pkg;

    localparam int CQ_DATA_W = 64;

    // Request opcodes carried in the CQ header.
    typedef enum logic [3:0] {
        MEM_RD = 4'h0,
        MEM_WR = 4'h1,
        IO_RD  = 4'h2,
        IO_WR  = 4'h3
    } req_type_e;

    typedef enum logic [2:0] {
        SC = 3'b000,  // Successful completion.
        UR = 3'b001   // Unsupported request.
    } cpl_status_e;

    // Header in the first CQ beat, 64 bits.
    typedef struct packed {
        logic [12:0] pad;
        logic [15:0] requester_id;
        logic [15:0] dword_addr;
        logic [3:0]  first_be;
        logic [7:0]  tag;
        logic [2:0]  bar_id;
        req_type_e   req_type;
    } cq_hdr_t;

    typedef struct packed {
        logic [CQ_DATA_W-1:0] data;
        logic                 last;
    } cq_beat_t;

    // One completion beat on CC.
    typedef struct packed {
        logic [7:0]  tag;
        logic [15:0] requester_id;
        cpl_status_e status;
        logic [6:0]  lower_addr;
        logic [31:0] data;
    } cc_cpl_t;

endpackage

//--- test/clk_gen.sv
/* Testbench clock */

`timescale 1ns/10ps

module clk_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period.
    end
endmodule

//--- test/fpga_core_chk.sv
/* CC handshake and status assertions */

`timescale 1ns/10ps

module fpga_core_chk (
    input logic                  clk,
    input logic                  rst_n,
    input pcie_tlp_pkg::cc_cpl_t cc_cpl,
    input logic                  cc_valid,
    input logic                  cc_ready,
    input logic                  status_error_cor
);

    // A stalled completion keeps its valid and its beat.
    cc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cc_valid && !cc_ready |=> cc_valid && $stable(cc_cpl))
        else $error("cc_cpl changed while stalled");

    cc_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(cc_valid))
        else $error("cc_valid is unknown");

    cor_single: assert property (@(posedge clk) disable iff (!rst_n)
        status_error_cor |=> !status_error_cor)
        else $error("status_error_cor high for two cycles");

endmodule

bind fpga_core fpga_core_chk u_chk (
    .clk(clk),
    .rst_n(rst_n),
    .cc_cpl(cc_cpl),
    .cc_valid(cc_valid),
    .cc_ready(cc_ready),
    .status_error_cor(status_error_cor)
);

//--- test/tb_fpga_core.sv
/* PCIe target core testbench */

`timescale 1ns/10ps

module tb_fpga_core;
    import pcie_tlp_pkg::*;
    import core_cfg_pkg::*;

    localparam int TIMEOUT = 500;  // Cycles allowed per wait.

    logic        clk;
    logic        rst_n;
    cq_beat_t    cq_beat;
    logic        cq_valid;
    logic        cq_ready;
    cc_cpl_t     cc_cpl;
    logic        cc_valid;
    logic        cc_ready;
    logic        status_error_cor;
    logic        status_error_uncor;
    logic [31:0] model [REG_DEPTH];  // Reference copy of BAR0.
    cc_cpl_t     exp_q [$];
    logic [15:0] lfsr;
    logic        stall_en;
    int          errors;
    int          checks;
    int          cor_count;
    int          unsup_sent;
    logic [7:0]  tag_ctr;

    clk_gen u_clk (.clk(clk));

    fpga_core u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .cq_beat(cq_beat),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),
        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready),
        .status_error_cor(status_error_cor),
        .status_error_uncor(status_error_uncor)
    );

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Applies one request to the model and gives the completion it should produce.
    function automatic cc_cpl_t ref_model(input cq_hdr_t hdr, input logic [31:0] wdata,
                                          output logic has_cpl);
        cc_cpl_t    cpl;
        logic       unsup;
        logic [1:0] idx;
        unsup = (hdr.bar_id != 3'd0) || (hdr.req_type != MEM_RD && hdr.req_type != MEM_WR);
        casez (hdr.first_be)
            4'b???1: idx = 2'd0;
            4'b??10: idx = 2'd1;
            4'b?100: idx = 2'd2;
            4'b1000: idx = 2'd3;
            default: idx = 2'd0;
        endcase
        cpl.tag          = hdr.tag;
        cpl.requester_id = hdr.requester_id;
        cpl.status       = unsup ? UR : SC;
        cpl.lower_addr   = {hdr.dword_addr[4:0], idx};
        cpl.data         = '0;
        has_cpl          = 1'b1;
        if (!unsup && hdr.req_type == MEM_WR) begin
            for (int b = 0; b < 4; b++) begin
                if (hdr.first_be[b]) begin
                    model[hdr.dword_addr[7:0]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            has_cpl = 1'b0;  // Posted write.
        end else if (!unsup) begin
            cpl.data = model[hdr.dword_addr[7:0]];
        end
        return cpl;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Some tests failed");
        $finish;
    endtask

    // Holds one CQ beat until it is accepted.
    task automatic send_beat(input logic [63:0] data, input logic last);
        int n;
        n            = 0;
        cq_beat.data = data;
        cq_beat.last = last;
        cq_valid     = 1'b1;
        @(posedge clk);
        while (!cq_ready) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("cq_ready");
            end
            @(posedge clk);
        end
        #1;
        cq_valid = 1'b0;
    endtask

    task automatic issue_req(input req_type_e rt, input logic [2:0] bar, input logic [7:0] addr,
                             input logic [3:0] be, input logic [31:0] wdata,
                             input logic data_last);
        cq_hdr_t hdr;
        cc_cpl_t cpl;
        logic    has_cpl;
        hdr              = '0;
        hdr.req_type     = rt;
        hdr.bar_id       = bar;
        hdr.tag          = tag_ctr;
        hdr.first_be     = be;
        hdr.dword_addr   = {8'h00, addr};
        hdr.requester_id = {8'h5A, ~tag_ctr};
        tag_ctr++;
        cpl = ref_model(hdr, wdata, has_cpl);
        if (has_cpl) begin
            exp_q.push_back(cpl);
        end
        if (cpl.status == UR) begin
            unsup_sent++;
        end
        if (rt == MEM_WR) begin
            send_beat(hdr, 1'b0);
            if (!data_last) begin
                send_beat({32'd0, ~wdata}, 1'b0);  // Data beat without last.
            end
            send_beat({32'd0, wdata}, 1'b1);
        end else begin
            send_beat(hdr, 1'b1);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                abort_run("outstanding completions");
            end
        end
    endtask

    // Host side of CC, stalls only during the burst.
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            cc_ready = (rand_bits(2) != 32'd0);
        end else begin
            cc_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cc_cpl_t exp;
        if (rst_n && status_error_cor) begin
            cor_count++;
        end
        if (rst_n && cc_valid && cc_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("[FAIL] %0t: unexpected completion %h", $time, cc_cpl);
            end else begin
                exp = exp_q.pop_front();
                checks++;
                if (cc_cpl !== exp) begin
                    errors++;
                    $display("[FAIL] %0t: completion %h, expected %h", $time, cc_cpl, exp);
                end
            end
        end
    end

    initial begin
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [7:0]  burst_addr [16];
        lfsr       = 16'd54;
        errors     = 0;
        checks     = 0;
        cor_count  = 0;
        unsup_sent = 0;
        tag_ctr    = 8'h10;
        stall_en   = 1'b0;
        cq_beat    = '0;
        cq_valid   = 1'b0;
        cc_ready   = 1'b1;
        rst_n      = 1'b0;
        for (int i = 0; i < REG_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        check_bit(cc_valid, 1'b0, "cc_valid after reset");
        check_bit(status_error_cor, 1'b0, "status_error_cor after reset");
        check_bit(status_error_uncor, 1'b0, "status_error_uncor after reset");
        check_bit(cq_ready, 1'b1, "cq_ready after reset");
        issue_req(MEM_RD, 3'd0, 8'(rand_bits(8)), 4'hF, 32'd0, 1'b1);
        wait_drain();

        // Full writes first, then partial ones over the same few dwords.
        for (int i = 0; i < 12; i++) begin
            addr  = 8'(rand_bits(3));
            wdata = rand_bits(32);
            be    = (i < 4) ? 4'hF : 4'(rand_bits(4));
            issue_req(MEM_WR, 3'd0, addr, be, wdata, 1'b1);
            issue_req(MEM_RD, 3'd0, addr, 4'(rand_bits(4)), 32'd0, 1'b1);
        end
        wait_drain();

        addr = 8'(rand_bits(3));
        issue_req(MEM_RD, 3'd2, addr, 4'hF, 32'd0, 1'b1);
        issue_req(MEM_WR, 3'd2, addr, 4'hF, 32'hDEAD_BEEF, 1'b1);
        issue_req(req_type_e'(4'h9), 3'd0, addr, 4'h4, 32'd0, 1'b1);
        issue_req(MEM_RD, 3'd0, addr, 4'hF, 32'd0, 1'b1);
        wait_drain();
        check_bit(cor_count == unsup_sent, 1'b1, "status_error_cor pulse count");

        for (int i = 0; i < 16; i++) begin
            burst_addr[i] = 8'(rand_bits(3));
        end
        @(posedge clk);
        stall_en = 1'b1;
        #1;
        for (int i = 0; i < 16; i++) begin
            issue_req(MEM_RD, 3'd0, burst_addr[i], 4'hF, 32'd0, 1'b1);
        end
        wait_drain();
        @(posedge clk);
        stall_en = 1'b0;
        #1;

        check_bit(status_error_uncor, 1'b0, "status_error_uncor before bad framing");
        addr  = 8'(rand_bits(3));
        wdata = rand_bits(32);
        issue_req(MEM_WR, 3'd0, addr, 4'hF, wdata, 1'b0);
        issue_req(MEM_RD, 3'd0, addr, 4'hF, 32'd0, 1'b1);
        wait_drain();
        check_bit(status_error_uncor, 1'b1, "status_error_uncor after bad framing");
        repeat (20) @(posedge clk);
        #1;
        check_bit(status_error_uncor, 1'b1, "status_error_uncor held");
        check_bit(cor_count == unsup_sent, 1'b1, "final status_error_cor pulse count");

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
